//--- bft.f
+incdir+source
source/bft_pkg.sv
source/route_decoder.sv
source/deflect_arbiter.sv
source/tree_switch.sv
source/leaf_port.sv
source/bft_top.sv
test/bft_tb.sv

//--- run.sh
#!/usr/bin/env bash
# compile and run the bft regression with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f bft.f --top-module bft_tb -Mdir obj_dir \
	&& ./obj_dir/Vbft_tb > sim.log 2>&1

cat sim.log 2>/dev/null
grep -q "^Regression passed$" sim.log 2>/dev/null && echo "PASS" || { echo "FAIL"; exit 1; }

//--- source/bft_config.svh
`ifndef BFT_CONFIG_SVH
`define BFT_CONFIG_SVH

// leaf ports at the bottom of the tree
`define BFT_NUM_LEAVES 8

// payload is the address width plus 4
`define BFT_PAYLOAD_W 7

// switch levels, also the width of a leaf address
`define BFT_DEPTH 3

`endif

//--- source/bft_pkg.sv
`include "bft_config.svh"

package bft_pkg;

	typedef logic [`BFT_DEPTH-1:0] leaf_addr_t;
	typedef logic [`BFT_PAYLOAD_W-1:0] payload_t;

	// valid on top, then destination, then payload
	typedef logic [$bits(leaf_addr_t)+$bits(payload_t):0] flit_t;

	// wanted direction of a flit, also the mux select of an output
	typedef enum logic [1:0] {
		DIR_VOID  = 2'b00,
		DIR_LEFT  = 2'b01,
		DIR_RIGHT = 2'b10,
		DIR_UP    = 2'b11
	} dir_t;

	function automatic logic flit_valid(flit_t f);
		return f[$bits(flit_t)-1];
	endfunction

	function automatic leaf_addr_t flit_addr(flit_t f);
		return f[$bits(flit_t)-2 -: $bits(leaf_addr_t)];
	endfunction

endpackage

//--- source/bft_top.sv
`timescale 1ns/1ps
`include "bft_config.svh"

module bft_top (
	input logic clk,
	input logic reset,
	input bft_pkg::flit_t pe_flit_i [`BFT_NUM_LEAVES],
	output bft_pkg::flit_t pe_flit_o [`BFT_NUM_LEAVES],
	output logic [`BFT_NUM_LEAVES-1:0] resend_o
);

	import bft_pkg::*;

	// nodes numbered as a heap: root is 1, children of n are 2n and 2n+1
	// leaf j sits at heap index NUM_LEAVES + j
	// dn_bus[n] runs from the parent into node n, up_bus[n] the other way
	flit_t dn_bus [2:2*`BFT_NUM_LEAVES-1];
	flit_t up_bus [2:2*`BFT_NUM_LEAVES-1];

	genvar n;
	genvar j;

	generate
		for (n = 1; n < `BFT_NUM_LEAVES; n++) begin : g_sw
			localparam int lvl = $clog2(n + 1) - 1;
			localparam int node = n - (1 << lvl);

			if (n == 1) begin : g_root
				tree_switch #(.level(lvl), .node_addr(node)) u_sw (
					.clk(clk),
					.reset(reset),
					.l_bus_i(up_bus[2*n]),
					.r_bus_i(up_bus[2*n+1]),
					.u_bus_i(),
					.l_bus_o(dn_bus[2*n]),
					.r_bus_o(dn_bus[2*n+1]),
					.u_bus_o()
				);
			end else begin : g_inner
				tree_switch #(.level(lvl), .node_addr(node)) u_sw (
					.clk(clk),
					.reset(reset),
					.l_bus_i(up_bus[2*n]),
					.r_bus_i(up_bus[2*n+1]),
					.u_bus_i(dn_bus[n]),
					.l_bus_o(dn_bus[2*n]),
					.r_bus_o(dn_bus[2*n+1]),
					.u_bus_o(up_bus[n])
				);
			end
		end

		for (j = 0; j < `BFT_NUM_LEAVES; j++) begin : g_leaf
			leaf_port #(.leaf_addr(j)) u_leaf (
				.clk(clk),
				.reset(reset),
				.bus_i(dn_bus[`BFT_NUM_LEAVES+j]),
				.bus_o(up_bus[`BFT_NUM_LEAVES+j]),
				.pe_flit_i(pe_flit_i[j]),
				.pe_flit_o(pe_flit_o[j]),
				.resend_o(resend_o[j])
			);
		end
	endgenerate

endmodule

//--- source/deflect_arbiter.sv
`timescale 1ns/1ps

module deflect_arbiter #(
	parameter int level = 1
) (
	input bft_pkg::dir_t d_l_i,
	input bft_pkg::dir_t d_r_i,
	input bft_pkg::dir_t d_u_i,
	output bft_pkg::dir_t sel_l_o,
	output bft_pkg::dir_t sel_r_o,
	output bft_pkg::dir_t sel_u_o
);

	import bft_pkg::*;

	generate
		if (level == 0) begin : g_root
			// root has no parent, every flit heads down to a child
			always_comb begin
				sel_l_o = DIR_VOID;
				sel_r_o = DIR_VOID;
				sel_u_o = DIR_VOID;
				if (d_l_i == DIR_LEFT)
					sel_l_o = DIR_LEFT;
				if (d_r_i == DIR_RIGHT)
					sel_r_o = DIR_RIGHT;
				if (d_l_i == DIR_RIGHT) begin
					if (sel_r_o == DIR_VOID)
						sel_r_o = DIR_LEFT;
					else
						sel_l_o = DIR_LEFT;
				end
				if (d_r_i == DIR_LEFT) begin
					if (sel_l_o == DIR_VOID)
						sel_l_o = DIR_RIGHT;
					else
						sel_r_o = DIR_RIGHT;
				end
			end
		end else begin : g_inner
			always_comb begin
				sel_l_o = DIR_VOID;
				sel_r_o = DIR_VOID;
				sel_u_o = DIR_VOID;

				// turnbacks go back out the link they came in on
				if (d_l_i == DIR_LEFT)
					sel_l_o = DIR_LEFT;
				if (d_r_i == DIR_RIGHT)
					sel_r_o = DIR_RIGHT;
				if (d_u_i == DIR_UP)
					sel_u_o = DIR_UP;

				// downlinks, bounced back up when the child link is taken
				if (d_u_i == DIR_LEFT) begin
					if (sel_l_o == DIR_VOID)
						sel_l_o = DIR_UP;
					else
						sel_u_o = DIR_UP;
				end
				if (d_u_i == DIR_RIGHT) begin
					if (sel_r_o == DIR_VOID)
						sel_r_o = DIR_UP;
					else
						sel_u_o = DIR_UP;
				end

				// side links between the two children
				if (d_l_i == DIR_RIGHT) begin
					if (sel_r_o == DIR_VOID)
						sel_r_o = DIR_LEFT;
					else if (sel_l_o == DIR_VOID)
						sel_l_o = DIR_LEFT;
					else
						sel_u_o = DIR_LEFT;
				end
				if (d_r_i == DIR_LEFT) begin
					if (sel_l_o == DIR_VOID)
						sel_l_o = DIR_RIGHT;
					else if (sel_r_o == DIR_VOID)
						sel_r_o = DIR_RIGHT;
					else
						sel_u_o = DIR_RIGHT;
				end

				// uplinks last, prefer bouncing back to the sender
				if (d_l_i == DIR_UP) begin
					if (sel_u_o == DIR_VOID)
						sel_u_o = DIR_LEFT;
					else if (sel_l_o == DIR_VOID)
						sel_l_o = DIR_LEFT;
					else
						sel_r_o = DIR_LEFT;
				end
				if (d_r_i == DIR_UP) begin
					if (sel_u_o == DIR_VOID)
						sel_u_o = DIR_RIGHT;
					else if (sel_r_o == DIR_VOID)
						sel_r_o = DIR_RIGHT;
					else
						sel_l_o = DIR_RIGHT;
				end
				// three inputs, three outputs, so the last branch is always free
			end
		end
	endgenerate

endmodule

//--- source/leaf_port.sv
`timescale 1ns/1ps

module leaf_port #(
	parameter int leaf_addr = 0
) (
	input logic clk,
	input logic reset,
	input bft_pkg::flit_t bus_i,
	output bft_pkg::flit_t bus_o,
	input bft_pkg::flit_t pe_flit_i,
	output bft_pkg::flit_t pe_flit_o,
	output logic resend_o
);

	import bft_pkg::*;

	logic eject;

	// flit for this leaf leaves the network here
	assign eject = flit_valid(bus_i) && (flit_addr(bus_i) == leaf_addr_t'(leaf_addr));

	// slot busy with a passing flit so the PE must hold its own
	assign resend_o = flit_valid(bus_i) && !eject;

	always_ff @(posedge clk) begin
		if (reset) begin
			pe_flit_o <= '0;
			bus_o <= '0;
		end else begin
			if (eject)
				pe_flit_o <= bus_i;
			else
				pe_flit_o <= '0;

			if (resend_o)
				bus_o <= bus_i;
			else if (flit_valid(pe_flit_i))
				bus_o <= pe_flit_i;
			else
				bus_o <= '0;
		end
	end

endmodule

//--- source/route_decoder.sv
`timescale 1ns/1ps

module route_decoder #(
	parameter int level = 0,
	parameter int node_addr = 0
) (
	input bft_pkg::flit_t flit_i,
	output bft_pkg::dir_t dir_o
);

	import bft_pkg::*;

	localparam int addr_w = $bits(leaf_addr_t);

	leaf_addr_t dest;
	logic in_subtree;

	assign dest = flit_addr(flit_i);

	// upper level bits name the subtree below this node
	// at the root the shift leaves nothing, so every flit matches
	assign in_subtree = (dest >> (addr_w - level)) == leaf_addr_t'(node_addr);

	always_comb begin
		if (!flit_valid(flit_i)) begin
			dir_o = DIR_VOID;
		end else if (!in_subtree) begin
			dir_o = DIR_UP;
		end else if (dest[addr_w-1-level]) begin
			// next bit picks the child
			dir_o = DIR_RIGHT;
		end else begin
			dir_o = DIR_LEFT;
		end
	end

endmodule

//--- source/tree_switch.sv
`timescale 1ns/1ps

module tree_switch #(
	parameter int level = 1,
	parameter int node_addr = 0
) (
	input logic clk,
	input logic reset,
	input bft_pkg::flit_t l_bus_i,
	input bft_pkg::flit_t r_bus_i,
	input bft_pkg::flit_t u_bus_i,
	output bft_pkg::flit_t l_bus_o,
	output bft_pkg::flit_t r_bus_o,
	output bft_pkg::flit_t u_bus_o
);

	import bft_pkg::*;

	dir_t d_l;
	dir_t d_r;
	dir_t d_u;
	dir_t sel_l;
	dir_t sel_r;
	dir_t sel_u;
	flit_t u_flit;
	logic [1:0] n_in;
	logic [1:0] n_out;

	function automatic flit_t pick(dir_t sel, flit_t l, flit_t r, flit_t u);
		case (sel)
			DIR_LEFT: return l;
			DIR_RIGHT: return r;
			DIR_UP: return u;
			default: return '0;
		endcase
	endfunction

	route_decoder #(.level(level), .node_addr(node_addr)) u_dec_l (
		.flit_i(l_bus_i),
		.dir_o(d_l)
	);

	route_decoder #(.level(level), .node_addr(node_addr)) u_dec_r (
		.flit_i(r_bus_i),
		.dir_o(d_r)
	);

	generate
		if (level == 0) begin : g_root
			// no parent link at the root
			assign d_u = DIR_VOID;
			assign u_flit = '0;
		end else begin : g_inner
			route_decoder #(.level(level), .node_addr(node_addr)) u_dec_u (
				.flit_i(u_bus_i),
				.dir_o(d_u)
			);
			assign u_flit = u_bus_i;
		end
	endgenerate

	deflect_arbiter #(.level(level)) u_arb (
		.d_l_i(d_l),
		.d_r_i(d_r),
		.d_u_i(d_u),
		.sel_l_o(sel_l),
		.sel_r_o(sel_r),
		.sel_u_o(sel_u)
	);

	always_ff @(posedge clk) begin
		if (reset) begin
			l_bus_o <= '0;
			r_bus_o <= '0;
			u_bus_o <= '0;
		end else begin
			l_bus_o <= pick(sel_l, l_bus_i, r_bus_i, u_flit);
			r_bus_o <= pick(sel_r, l_bus_i, r_bus_i, u_flit);
			u_bus_o <= pick(sel_u, l_bus_i, r_bus_i, u_flit);
		end
	end

	// flits in must equal flits out one cycle later
	assign n_in = {1'b0, flit_valid(l_bus_i)} + {1'b0, flit_valid(r_bus_i)}
		+ {1'b0, flit_valid(u_flit)};
	assign n_out = {1'b0, flit_valid(l_bus_o)} + {1'b0, flit_valid(r_bus_o)}
		+ {1'b0, flit_valid(u_bus_o)};

	a_conserve: assert property (@(posedge clk) disable iff (reset)
		!$past(reset) |-> n_out == $past(n_in))
		else $error("tree_switch level %0d node %0d lost or duplicated a flit",
			level, node_addr);

endmodule

//--- test/bft_tb.sv
`timescale 1ns/1ps
`include "bft_config.svh"

module bft_tb;

	import bft_pkg::*;

	localparam int num_leaves = `BFT_NUM_LEAVES;
	localparam int pay_w = `BFT_PAYLOAD_W;
	localparam int addr_w = `BFT_DEPTH;
	localparam int num_tags = 1 << pay_w;
	localparam int valid_bit = addr_w + pay_w;
	localparam int random_packets = 120;
	localparam int drain_cycles = 50;
	// 56 serial trips plus a 7 flit burst and 120 random packets
	// each trip stays far below a hundred cycles even with many deflections
	localparam int timeout_cycles = 20000;

	logic clk;
	logic reset;
	flit_t pe_flit_i [num_leaves];
	flit_t pe_flit_o [num_leaves];
	logic [num_leaves-1:0] resend_o;

	// flits waiting per leaf
	// the head sits on pe_flit_i once presented
	flit_t inject_q [num_leaves][$];

	// scoreboard indexed by tag
	// entries stamped with the phase they belong to
	int expected_phase [num_tags];
	int delivered_phase [num_tags];
	flit_t sent_flit [num_tags];
	int phase_id;
	int delivered_count;
	int cycle_count;
	string test_name;

	bft_top u_dut (
		.clk(clk),
		.reset(reset),
		.pe_flit_i(pe_flit_i),
		.pe_flit_o(pe_flit_o),
		.resend_o(resend_o)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("Regression failed");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual)
			abort_run($sformatf("FAILED %s: expected 0x%0h, actual 0x%0h",
				name, expected, actual));
	endtask

	// destination leaf and payload that a sent flit must arrive with
	function automatic logic [addr_w+pay_w-1:0] expected_delivery(input flit_t sent);
		logic [addr_w-1:0] dest;
		logic [pay_w-1:0] payload;
		dest = sent[pay_w +: addr_w];
		payload = sent[pay_w-1:0];
		return {dest, payload};
	endfunction

	function automatic flit_t make_flit(input int dst, input int tag);
		return {1'b1, leaf_addr_t'(dst), payload_t'(tag)};
	endfunction

	// called on a falling edge away from the injector
	task automatic queue_packet(input int src, input int dst, input int tag);
		flit_t f;
		f = make_flit(dst, tag);
		sent_flit[tag] = f;
		expected_phase[tag] = phase_id;
		inject_q[src].push_back(f);
	endtask

	task automatic start_phase(input string name);
		@(negedge clk);
		phase_id++;
		test_name = name;
	endtask

	task automatic wait_for_deliveries(input int target);
		while (delivered_count < target)
			@(negedge clk);
	endtask

	task automatic check_idle(input string name);
		logic [num_leaves-1:0] valid_mask;
		for (int k = 0; k < num_leaves; k++)
			valid_mask[k] = pe_flit_o[k][valid_bit];
		check_value(name, 32'(0), 32'(valid_mask));
		check_value(name, 32'(0), 32'(resend_o));
	endtask

	// injectors of all leaves step on the same edge
	initial begin
		for (int g = 0; g < num_leaves; g++)
			pe_flit_i[g] <= '0;
		forever begin
			@(posedge clk);
			for (int g = 0; g < num_leaves; g++) begin
				if (reset) begin
					pe_flit_i[g] <= '0;
				end else if (pe_flit_i[g][valid_bit] && resend_o[g]) begin
					// slot taken by a passing flit so hold ours
					pe_flit_i[g] <= pe_flit_i[g];
				end else if (inject_q[g].size() > 0) begin
					pe_flit_i[g] <= inject_q[g].pop_front();
				end else begin
					pe_flit_i[g] <= '0;
				end
			end
		end
	end

	// every delivered flit is matched against the scoreboard by its tag
	initial begin
		int tag;
		logic [addr_w+pay_w-1:0] exp;
		for (int t = 0; t < num_tags; t++)
			delivered_phase[t] = -1;
		delivered_count = 0;
		forever begin
			@(posedge clk);
			for (int k = 0; k < num_leaves; k++) begin
				if (!reset && pe_flit_o[k][valid_bit]) begin
					tag = int'(pe_flit_o[k][pay_w-1:0]);
					if (expected_phase[tag] != phase_id)
						abort_run($sformatf("%s: leaf %0d delivered tag %0d, which was not sent",
							test_name, k, tag));
					if (delivered_phase[tag] == phase_id)
						abort_run($sformatf("%s: tag %0d was delivered a second time at leaf %0d",
							test_name, tag, k));
					exp = expected_delivery(sent_flit[tag]);
					check_value(test_name, 32'(exp[pay_w +: addr_w]), 32'(k));
					check_value(test_name, 32'({1'b1, exp}), 32'(pe_flit_o[k]));
					delivered_phase[tag] = phase_id;
					delivered_count++;
				end
			end
		end
	end

	initial begin
		cycle_count = 0;
		while (cycle_count < timeout_cycles) begin
			@(posedge clk);
			cycle_count++;
		end
		abort_run($sformatf("timeout: the tests did not finish within %0d cycles",
			timeout_cycles));
	end

	initial begin
		int tag;
		int src;
		int dst;
		int base;
		void'($urandom(76523));
		phase_id = 0;
		test_name = "reset";
		for (int t = 0; t < num_tags; t++)
			expected_phase[t] = -1;

		reset <= 1'b1;
		repeat (3) @(posedge clk);
		reset <= 1'b0;
		repeat (3) begin
			@(posedge clk);
			check_idle("reset");
		end

		// one packet in flight at a time over every ordered leaf pair
		start_phase("single paths");
		tag = 0;
		for (src = 0; src < num_leaves; src++) begin
			for (dst = 0; dst < num_leaves; dst++) begin
				if (dst != src) begin
					base = delivered_count;
					queue_packet(src, dst, tag);
					tag++;
					wait_for_deliveries(base + 1);
				end
			end
		end

		// everyone else aims at leaf 0 in the same cycle
		start_phase("hot spot");
		base = delivered_count;
		for (src = 1; src < num_leaves; src++)
			queue_packet(src, 0, src);
		wait_for_deliveries(base + num_leaves - 1);

		start_phase("random traffic");
		base = delivered_count;
		for (tag = 0; tag < random_packets; tag++) begin
			src = int'($urandom_range(num_leaves - 1, 0));
			dst = int'($urandom_range(num_leaves - 1, 0));
			queue_packet(src, dst, tag);
		end
		wait_for_deliveries(base + random_packets);

		// network must be empty now
		start_phase("drain");
		repeat (drain_cycles) begin
			@(posedge clk);
			check_idle("drain");
		end

		$display("Regression passed");
		$finish;
	end

endmodule
